//--- accel_pkg.sv
`default_nettype none

package accel_pkg;

   // link field widths
   localparam int addr_width   = 16;
   localparam int data_width   = 32;
   localparam int mask_width   = data_width / 8;
   localparam int x_cord_width = 4;
   localparam int y_cord_width = 4;

   // remote op field, store is the only op this tile sends
   localparam int op_width = 2;
   localparam logic [op_width-1:0]   op_store = 2'b01;
   localparam logic [mask_width-1:0] mask_all = '1;

   // receive fifo sizing
   localparam int rx_fifo_els  = 4;
   localparam int rx_ptr_width = $clog2(rx_fifo_els);
   localparam int rx_cnt_width = $clog2(rx_fifo_els + 1);
   localparam logic [rx_cnt_width-1:0] rx_cnt_full = rx_cnt_width'(rx_fifo_els);

   // outbound credits, counter must hold 0 up to the full count
   localparam int max_out_credits = 4;
   localparam int credit_width    = $clog2(max_out_credits + 1);
   localparam logic [credit_width-1:0] credit_full = credit_width'(max_out_credits);

   // inbound remote store as seen by the tile
   typedef struct packed {
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
      logic [mask_width-1:0] mask;
   } rx_req_s;

   // data word written to address 0, low bits carry the outgoing address
   typedef struct packed {
      logic [data_width-addr_width-1:0] rsvd;
      logic [addr_width-1:0]            addr;
   } cfg_addr_view_s;

   // data word written to address 1, low bits carry y then x
   typedef struct packed {
      logic [data_width-y_cord_width-x_cord_width-1:0] rsvd;
      logic [y_cord_width-1:0]                         y_cord;
      logic [x_cord_width-1:0]                         x_cord;
   } cfg_dest_view_s;

   // one config word, decoded by which address it was written to
   typedef union packed {
      cfg_addr_view_s out_addr;
      cfg_dest_view_s dest;
   } cfg_word_u;

   typedef struct packed {
      logic [addr_width-1:0]   addr;
      logic [y_cord_width-1:0] y_cord;
      logic [x_cord_width-1:0] x_cord;
      logic [y_cord_width-1:0] src_y_cord;
      logic [x_cord_width-1:0] src_x_cord;
      logic [op_width-1:0]     op;
      logic [mask_width-1:0]   mask;
      logic [data_width-1:0]   data;
   } tx_pkt_s;

   // buffer stage to outbound stage
   typedef struct packed {
      tx_pkt_s pkt;
   } fwd_req_s;

   // low two address bits select the function
   typedef enum logic [1:0] {
      sel_addr = 2'd0,
      sel_dest = 2'd1,
      sel_fwd  = 2'd2,
      sel_none = 2'd3
   } sel_e;

endpackage

`default_nettype wire

//--- accel_rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module accel_rx_fifo
   import accel_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   // link side
   input  logic    rx_v_i,
   input  rx_req_s rx_req_i,
   output logic    rx_ready_o,
   // decoder side
   output logic    head_v_o,
   output rx_req_s head_o,
   input  logic    head_yumi_i
);

   rx_req_s                 mem [rx_fifo_els];
   logic [rx_ptr_width-1:0] wr_ptr_r;
   logic [rx_ptr_width-1:0] rd_ptr_r;
   logic [rx_cnt_width-1:0] count_r;
   logic                    push;
   logic                    pop;

   // a pop frees a slot in the same cycle, so a full fifo can still take one
   assign rx_ready_o = (count_r != rx_cnt_full) | head_yumi_i;
   assign push       = rx_v_i & rx_ready_o;
   assign pop        = head_yumi_i;

   // oldest entry sits at the read pointer
   assign head_v_o = (count_r != '0);
   assign head_o   = mem[rd_ptr_r];

   // storage only, occupancy lives in the count
   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem[wr_ptr_r] <= rx_req_i;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_r <= rd_ptr_r + 1'b1;
         end
         // push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   // decoder must never pop an empty fifo
   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      head_yumi_i |-> head_v_o);

   // occupancy stays within the depth
   a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      count_r <= rx_cnt_full);

endmodule

`default_nettype wire

//--- accel_cfg_fwd.sv
`timescale 1ns/1ns
`default_nettype none

module accel_cfg_fwd
   import accel_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   // head of the receive fifo
   input  logic                    head_v_i,
   input  rx_req_s                 head_i,
   output logic                    head_yumi_o,
   // forward path to the outbound stage
   output logic                    fwd_v_o,
   output fwd_req_s                fwd_o,
   input  logic                    fwd_ready_i,
   // tile coordinates, used as the packet source
   input  logic [x_cord_width-1:0] my_x_i,
   input  logic [y_cord_width-1:0] my_y_i
);

   sel_e                    sel;
   cfg_word_u               cfg_w;
   logic [addr_width-1:0]   out_addr_r;
   logic [y_cord_width-1:0] dest_y_r;
   logic [x_cord_width-1:0] dest_x_r;

   // only the low two address bits matter
   assign sel   = sel_e'(head_i.addr[1:0]);
   assign cfg_w = head_i.data;

   // forward only address 2 heads
   assign fwd_v_o = head_v_i & (sel == sel_fwd);

   // config and ignored heads pop at once
   // address 2 waits for the outbound handshake so no data is dropped
   assign head_yumi_o = head_v_i & ((sel != sel_fwd) | fwd_ready_i);

   // configuration registers
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         out_addr_r <= '0;
         dest_y_r   <= '0;
         dest_x_r   <= '0;
      end
      else if (head_v_i)
      begin
         case (sel)
            // address view of the word
            sel_addr:
            begin
               out_addr_r <= cfg_w.out_addr.addr;
            end
            // y/x view of the same word
            sel_dest:
            begin
               dest_y_r <= cfg_w.dest.y_cord;
               dest_x_r <= cfg_w.dest.x_cord;
            end
            // forward and ignored heads leave config alone
            default:
            begin
               out_addr_r <= out_addr_r;
            end
         endcase
      end
   end

   // outgoing packet from config state, fixed fields and head data
   always_comb
   begin
      fwd_o.pkt.addr       = out_addr_r;
      fwd_o.pkt.y_cord     = dest_y_r;
      fwd_o.pkt.x_cord     = dest_x_r;
      fwd_o.pkt.src_y_cord = my_y_i;
      fwd_o.pkt.src_x_cord = my_x_i;
      fwd_o.pkt.op         = op_store;
      fwd_o.pkt.mask       = mask_all;
      fwd_o.pkt.data       = head_i.data;
   end

   // an address 2 head only leaves the fifo together with a forward transfer
   a_fwd_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (head_yumi_o && sel == sel_fwd) |-> (fwd_v_o && fwd_ready_i));

   // a stalled forward keeps its request, the fifo head must not move
   a_fwd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (fwd_v_o && !fwd_ready_i) |=> (fwd_v_o && $stable(fwd_o)));

endmodule

`default_nettype wire

//--- accel_tx_credit.sv
`timescale 1ns/1ns
`default_nettype none

module accel_tx_credit
   import accel_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   // forward path from the decoder
   input  logic     fwd_v_i,
   input  fwd_req_s fwd_i,
   output logic     fwd_ready_o,
   // link side
   output logic     tx_v_o,
   output tx_pkt_s  tx_pkt_o,
   input  logic     tx_ready_i,
   input  logic     credit_return_i
);

   logic                    slot_v_r;
   tx_pkt_s                 pkt_r;
   logic [credit_width-1:0] credit_r;
   logic                    send;
   logic                    accept;

   // packet leaves the slot on the link handshake
   assign send = slot_v_r & tx_ready_i;

   // need a credit, and the slot must be empty or draining this cycle
   assign fwd_ready_o = (credit_r != '0) & (~slot_v_r | tx_ready_i);
   assign accept      = fwd_v_i & fwd_ready_o;

   assign tx_v_o   = slot_v_r;
   assign tx_pkt_o = pkt_r;

   // payload, only loaded on accept
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         pkt_r <= fwd_i.pkt;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         slot_v_r <= 1'b0;
         credit_r <= credit_full;
      end
      else
      begin
         // refill wins over drain when both happen
         if (accept)
         begin
            slot_v_r <= 1'b1;
         end
         else if (send)
         begin
            slot_v_r <= 1'b0;
         end
         // a credit is spent when the forward is taken, not when it is sent
         case ({accept, credit_return_i})
            2'b10:   credit_r <= credit_r - 1'b1;
            2'b01:   credit_r <= credit_r + 1'b1;
            default: credit_r <= credit_r;
         endcase
      end
   end

   // link sees a steady packet while it stalls us
   a_tx_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (tx_v_o && !tx_ready_i) |=> (tx_v_o && $stable(tx_pkt_o)));

   a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_r <= credit_full);

   // the network cannot return a credit that was never spent
   a_no_extra_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_return_i |-> (credit_r != credit_full));

endmodule

`default_nettype wire

//--- accel_tile.sv
`timescale 1ns/1ns
`default_nettype none

module accel_tile
   import accel_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   // inbound link
   input  logic                    rx_v_i,
   input  rx_req_s                 rx_req_i,
   output logic                    rx_ready_o,
   // outbound link
   output logic                    tx_v_o,
   output tx_pkt_s                 tx_pkt_o,
   input  logic                    tx_ready_i,
   input  logic                    credit_return_i,
   // tile position in the mesh
   input  logic [x_cord_width-1:0] my_x_i,
   input  logic [y_cord_width-1:0] my_y_i
);

   // fifo head to decoder
   logic     head_v;
   rx_req_s  head;
   logic     head_yumi;
   // decoder to outbound stage
   logic     fwd_v;
   fwd_req_s fwd;
   logic     fwd_ready;

   // producer, buffers requests from the link
   accel_rx_fifo i_accel_rx_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rx_v_i      (rx_v_i),
      .rx_req_i    (rx_req_i),
      .rx_ready_o  (rx_ready_o),
      .head_v_o    (head_v),
      .head_o      (head),
      .head_yumi_i (head_yumi)
   );

   // buffer, config registers and forward generation
   accel_cfg_fwd i_accel_cfg_fwd (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .head_v_i    (head_v),
      .head_i      (head),
      .head_yumi_o (head_yumi),
      .fwd_v_o     (fwd_v),
      .fwd_o       (fwd),
      .fwd_ready_i (fwd_ready),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i)
   );

   // consumer, one packet slot plus credit counter
   accel_tx_credit i_accel_tx_credit (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .fwd_v_i         (fwd_v),
      .fwd_i           (fwd),
      .fwd_ready_o     (fwd_ready),
      .tx_v_o          (tx_v_o),
      .tx_pkt_o        (tx_pkt_o),
      .tx_ready_i      (tx_ready_i),
      .credit_return_i (credit_return_i)
   );

endmodule

`default_nettype wire

//--- tb_accel_tile.sv
`timescale 1ns/1ns
`default_nettype none

module tb_accel_tile
   import accel_pkg::*;
();

   localparam int clk_period = 20;
   localparam int drive_dly  = 1;
   localparam int idle_win   = 20;
   localparam int n_rand     = 16;
   // 38 requests over all phases plus the idle windows of the credit test
   localparam int stim_cycles    = 22 + n_rand + 4 * idle_win;
   localparam int timeout_cycles = stim_cycles * 4 + 200;
   localparam logic [x_cord_width-1:0] tile_x = 4'd3;
   localparam logic [y_cord_width-1:0] tile_y = 4'd5;

   logic                    clk_i;
   logic                    rst_n_i;
   logic                    rx_v_i;
   rx_req_s                 rx_req_i;
   logic                    rx_ready_o;
   logic                    tx_v_o;
   tx_pkt_s                 tx_pkt_o;
   logic                    tx_ready_i = 1'b0;
   logic                    credit_return_i = 1'b0;
   logic [x_cord_width-1:0] my_x_i;
   logic [y_cord_width-1:0] my_y_i;

   // reference model state
   tx_pkt_s                 exp_q [$];
   tx_pkt_s                 exp_head;
   logic                    exp_have = 1'b0;
   tx_pkt_s                 m_pkt;
   logic [addr_width-1:0]   m_addr = '0;
   logic [y_cord_width-1:0] m_dest_y = '0;
   logic [x_cord_width-1:0] m_dest_x = '0;
   // link events seen at the falling edge
   logic                    rx_fire_q = 1'b0;
   logic                    tx_fire_q = 1'b0;
   logic                    ret_q = 1'b0;
   rx_req_s                 rx_req_q;
   int                      sent_cnt = 0;
   int                      out_cnt = 0;
   int                      errors = 0;
   int                      cycle_cnt = 0;
   int                      base;
   // stimulus control written at the falling edge
   logic [15:0]             lfsr;
   logic [1:0]              tx_mode = 2'd0;
   logic                    auto_ret = 1'b1;
   int                      ret_reqs = 0;
   int                      ret_done = 0;
   logic [data_width-1:0]   data_mem [64];
   logic [5:0]              req_idx = '0;

   accel_tile i_accel_tile (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .rx_v_i          (rx_v_i),
      .rx_req_i        (rx_req_i),
      .rx_ready_o      (rx_ready_o),
      .tx_v_o          (tx_v_o),
      .tx_pkt_o        (tx_pkt_o),
      .tx_ready_i      (tx_ready_i),
      .credit_return_i (credit_return_i),
      .my_x_i          (my_x_i),
      .my_y_i          (my_y_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #(clk_period / 2);
         clk_i = ~clk_i;
      end
   end

   // galois lfsr with taps 0xb400 and one step per bit
   function automatic logic lfsr_step();
      logic out_bit;
      out_bit = lfsr[0];
      lfsr = lfsr >> 1;
      if (out_bit)
      begin
         lfsr = lfsr ^ 16'hB400;
      end
      return out_bit;
   endfunction

   function automatic logic [data_width-1:0] rand_word();
      logic [data_width-1:0] w;
      w = '0;
      for (int b = 0; b < data_width; b++)
      begin
         w = {w[data_width-2:0], lfsr_step()};
      end
      return w;
   endfunction

   task automatic report(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic check_bit(input string sig, input logic exp_v, input logic act_v);
      assert (act_v == exp_v)
      else report($sformatf("** Error at %0t ns: %s expected %b, got %b",
         $time, sig, exp_v, act_v));
   endtask

   task automatic check_count(input string sig, input int exp_v, input int act_v);
      assert (act_v == exp_v)
      else report($sformatf("** Error at %0t ns: %s expected %0d, got %0d",
         $time, sig, exp_v, act_v));
   endtask

   // hold the request until the tile takes it
   // returns just after the transfer edge
   task automatic send_req(input logic [addr_width-1:0] a, input logic [data_width-1:0] d);
      logic hs;
      rx_v_i        = 1'b1;
      rx_req_i.addr = a;
      rx_req_i.data = d;
      rx_req_i.mask = mask_all;
      hs = 1'b0;
      while (!hs)
      begin
         @(negedge clk_i);
         hs = rx_ready_o;
         @(posedge clk_i);
         #(drive_dly);
      end
      rx_v_i = 1'b0;
   endtask

   task automatic send_fwd();
      send_req(16'd2, data_mem[req_idx]);
      req_idx = req_idx + 6'd1;
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk_i);
      #(drive_dly);
   endtask

   task automatic set_ctrl(input logic [1:0] mode, input logic ret);
      @(negedge clk_i);
      tx_mode  = mode;
      auto_ret = ret;
      idle(1);
   endtask

   task automatic return_credit();
      @(negedge clk_i);
      ret_reqs++;
      idle(1);
   endtask

   task automatic wait_sent(input int n);
      while (sent_cnt < n)
      begin
         idle(1);
      end
   endtask

   // every expected packet out and every credit back
   task automatic wait_drain();
      while (exp_have || out_cnt != 0)
      begin
         idle(1);
      end
   endtask

   // link side driver for the ready pattern and credit returns
   always @(posedge clk_i)
   begin
      #(drive_dly);
      case (tx_mode)
         2'd0:    tx_ready_i = 1'b1;
         2'd1:    tx_ready_i = 1'b0;
         default: tx_ready_i = lfsr_step();
      endcase
      if (ret_done != ret_reqs)
      begin
         credit_return_i = 1'b1;
         ret_done++;
      end
      else if (auto_ret && out_cnt != 0)
      begin
         credit_return_i = lfsr_step();
      end
      else
      begin
         credit_return_i = 1'b0;
      end
   end

   // inputs settle after the drive delay so the falling edge sees the transfer
   always @(negedge clk_i)
   begin
      rx_fire_q <= rx_v_i & rx_ready_o;
      rx_req_q  <= rx_req_i;
      tx_fire_q <= tx_v_o & tx_ready_i;
      ret_q     <= credit_return_i;
   end

   // model applies config writes in request order and queues a packet for address 2
   always @(posedge clk_i)
   begin
      if (rst_n_i)
      begin
         if (tx_fire_q)
         begin
            exp_q.delete(0);
            sent_cnt <= sent_cnt + 1;
         end
         if (tx_fire_q && !ret_q)
         begin
            out_cnt <= out_cnt + 1;
         end
         else if (!tx_fire_q && ret_q)
         begin
            out_cnt <= out_cnt - 1;
         end
         if (rx_fire_q)
         begin
            case (rx_req_q.addr[1:0])
               2'd0: m_addr = rx_req_q.data[addr_width-1:0];
               2'd1:
               begin
                  m_dest_y = rx_req_q.data[x_cord_width+y_cord_width-1:x_cord_width];
                  m_dest_x = rx_req_q.data[x_cord_width-1:0];
               end
               2'd2:
               begin
                  m_pkt.addr       = m_addr;
                  m_pkt.y_cord     = m_dest_y;
                  m_pkt.x_cord     = m_dest_x;
                  m_pkt.src_y_cord = tile_y;
                  m_pkt.src_x_cord = tile_x;
                  m_pkt.op         = op_store;
                  m_pkt.mask       = mask_all;
                  m_pkt.data       = rx_req_q.data;
                  exp_q.push_back(m_pkt);
               end
               // address 3 is dropped
               default: ;
            endcase
         end
         exp_have <= (exp_q.size() != 0);
         if (exp_q.size() != 0)
         begin
            exp_head <= exp_q[0];
         end
      end
   end

   a_tx_expected: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      (tx_v_o && tx_ready_i) |-> exp_have)
      else report($sformatf("tile sent a packet at %0t ns that no request asked for", $time));

   a_tx_match: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      (tx_v_o && tx_ready_i && exp_have) |-> (tx_pkt_o == exp_head))
      else report($sformatf("** Error at %0t ns: tx_pkt_o expected %0h, got %0h",
         $time, exp_head, tx_pkt_o));

   a_tx_hold: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      (tx_v_o && !tx_ready_i) |=> (tx_v_o && $stable(tx_pkt_o)))
      else report($sformatf("outbound packet moved at %0t ns while the link stalled", $time));

   a_credit_limit: assert property (@(negedge clk_i) disable iff (!rst_n_i)
      (tx_v_o && tx_ready_i) |-> (out_cnt < max_out_credits))
      else report($sformatf("packet sent at %0t ns with all credits in use", $time));

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles)
      begin
         $display("timeout: no progress after %0d cycles", cycle_cnt);
         $display("errors: %0d, packets sent: %0d, still expected: %0d",
            errors, sent_cnt, exp_q.size());
         $display("tests failed");
         $finish;
      end
   end

   initial
   begin
      lfsr = 16'd51740;
      for (int i = 0; i < 64; i++)
      begin
         data_mem[6'(i)] = rand_word();
      end
      rst_n_i  = 1'b0;
      rx_v_i   = 1'b0;
      rx_req_i = '0;
      my_x_i   = tile_x;
      my_y_i   = tile_y;
      repeat (10) @(posedge clk_i);
      #(drive_dly);
      rst_n_i = 1'b1;

      // idle tile after reset and an unconfigured forward to address 0 at node 0
      @(negedge clk_i);
      check_bit("tx_v_o", 1'b0, tx_v_o);
      check_bit("rx_ready_o", 1'b1, rx_ready_o);
      idle(1);
      send_fwd();
      wait_drain();

      // program address then destination and keep forwards in request order
      send_req(16'd0, 32'h0000_a5c4);
      send_req(16'd1, 32'h0000_0072);
      repeat (4) send_fwd();
      wait_drain();

      // credit limit with no returns until forced
      set_ctrl(2'd0, 1'b0);
      base = sent_cnt;
      repeat (6) send_fwd();
      wait_sent(base + max_out_credits);
      idle(idle_win);
      check_count("sent_cnt", base + max_out_credits, sent_cnt);
      return_credit();
      wait_sent(base + max_out_credits + 1);
      idle(idle_win);
      check_count("sent_cnt", base + max_out_credits + 1, sent_cnt);
      set_ctrl(2'd0, 1'b1);
      wait_drain();

      // stalled link fills the slot and the fifo
      set_ctrl(2'd1, 1'b1);
      repeat (rx_fifo_els + 1) send_fwd();
      @(negedge clk_i);
      check_bit("rx_ready_o", 1'b0, rx_ready_o);
      set_ctrl(2'd2, 1'b1);
      for (int i = 0; i < n_rand; i++)
      begin
         if (i % 4 == 3)
         begin
            send_req(addr_width'((i / 4) % 2), data_mem[req_idx]);
            req_idx = req_idx + 6'd1;
         end
         else
         begin
            send_fwd();
         end
      end
      wait_drain();

      // address 3 heads including some with high address bits set
      set_ctrl(2'd0, 1'b1);
      send_req(16'd3, 32'hffff_ffff);
      send_req(16'h0047, 32'hffff_ffff);
      send_fwd();
      send_fwd();
      wait_drain();
      idle(4);

      $display("errors: %0d, packets sent: %0d, still expected: %0d",
         errors, sent_cnt, exp_q.size());
      if (errors == 0)
      begin
         $display("all tests passed");
      end
      else
      begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
accel_pkg.sv
accel_rx_fifo.sv
accel_cfg_fwd.sv
accel_tx_credit.sv
accel_tile.sv
tb_accel_tile.sv

//--- Makefile
# Verilator build and run of the accelerator tile testbench
# override any variable on the command line, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_accel_tile
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit status
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS: $(LOG)"; \
	else \
		echo "FAIL: $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
